// ==== logic/dcache_geom_pkg.sv ====
// Address, word and line geometry of the data cache, imported by the RTL and the testbench
package dcache_geom_pkg;

    // ------------------------------------------------------------------
    // CPU and memory side widths
    // ------------------------------------------------------------------

    // Word address seen by the CPU and the memory
    localparam int ADDR_W = 19;

    // One data word and its byte lanes
    localparam int WORD_W = 16;
    localparam int BE_W   = 2;

    // ------------------------------------------------------------------
    // Line geometry
    // ------------------------------------------------------------------

    // Word offset inside a line, lowest address bits
    localparam int OFFSET_W   = 3;
    localparam int LINE_WORDS = 8;

    // Common types for ports and storage
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BE_W-1:0]   be_t;

endpackage

// ==== logic/dcache_ctrl_pkg.sv ====
// Cache controller FSM states and memory-operation codes, imported by the controller
package dcache_ctrl_pkg;

    // Miss handling sequence of the controller
    typedef enum logic [2:0] {
        IDLE,
        WB_READ,
        WB_SEND,
        FILL,
        APPLY_WRITE
    } ctrl_state_t;

    // Operation currently presented on the memory port
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

endpackage

// ==== logic/dcache_way.sv ====
// One way of the data cache: tag, valid, dirty and line data storage plus the tag compare
`timescale 1ns/10ps

module dcache_way #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_geom_pkg::ADDR_W - dcache_geom_pkg::OFFSET_W - IDX_W
) (
    input  logic                   clk,
    input  logic                   reset,
    // Lookup and compare
    input  dcache_geom_pkg::addr_t lookup_addr,
    input  dcache_geom_pkg::addr_t compare_addr,
    output logic                   hit,
    output dcache_geom_pkg::word_t rd_data,
    output logic                   valid,
    output logic                   dirty,
    output logic [TAG_W-1:0]       victim_tag,
    // CPU write hit or held write miss
    input  logic                   cpu_wr,
    input  dcache_geom_pkg::addr_t cpu_addr,
    input  dcache_geom_pkg::word_t cpu_wdata,
    input  dcache_geom_pkg::be_t   cpu_bytesel,
    // Line fill
    input  logic                   fill_start,
    input  logic                   fill_wr,
    input  dcache_geom_pkg::addr_t fill_addr,
    input  dcache_geom_pkg::word_t fill_wdata,
    input  logic                   fill_done,
    // Write-back of the victim line
    input  dcache_geom_pkg::addr_t wb_addr,
    output dcache_geom_pkg::word_t wb_data,
    input  logic                   wb_clean
);
    import dcache_geom_pkg::*;

    localparam int LINE_AW = IDX_W + OFFSET_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    word_t            data_mem [SETS*LINE_WORDS];
    logic [TAG_W-1:0] tag_q;
    logic [SETS-1:0]  valid_r;
    logic [SETS-1:0]  dirty_r;

    logic [IDX_W-1:0] cmp_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [IDX_W-1:0] cpu_idx;
    logic [IDX_W-1:0] wb_idx;

    assign cmp_idx  = compare_addr[OFFSET_W +: IDX_W];
    assign fill_idx = fill_addr[OFFSET_W +: IDX_W];
    assign cpu_idx  = cpu_addr[OFFSET_W +: IDX_W];
    assign wb_idx   = wb_addr[OFFSET_W +: IDX_W];

    // ------------------------------------------------------------------
    // Tag array, registered read on the lookup index
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_start) begin
            tag_mem[fill_idx] <= fill_addr[ADDR_W-1 -: TAG_W];
        end
        tag_q <= tag_mem[lookup_addr[OFFSET_W +: IDX_W]];
    end

    // ------------------------------------------------------------------
    // Line data, one write port shared by fill and CPU writes
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_wr) begin
            data_mem[fill_addr[LINE_AW-1:0]] <= fill_wdata;
        end else if (cpu_wr) begin
            for (int b = 0; b < BE_W; b++) begin
                if (cpu_bytesel[b]) begin
                    data_mem[cpu_addr[LINE_AW-1:0]][8*b +: 8] <= cpu_wdata[8*b +: 8];
                end
            end
        end
        rd_data <= data_mem[lookup_addr[LINE_AW-1:0]];
        // Second read port feeds the write-back path
        wb_data <= data_mem[wb_addr[LINE_AW-1:0]];
    end

    // ------------------------------------------------------------------
    // Per-set valid and dirty flags
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_r <= '0;
            dirty_r <= '0;
        end else begin
            // Line is invalid while its fill is in progress
            if (fill_start) begin
                valid_r[fill_idx] <= 1'b0;
            end else if (fill_done) begin
                valid_r[fill_idx] <= 1'b1;
            end

            if (cpu_wr) begin
                dirty_r[cpu_idx] <= 1'b1;
            end else if (wb_clean) begin
                dirty_r[wb_idx] <= 1'b0;
            end
        end
    end

    assign hit        = valid_r[cmp_idx] && (tag_q == compare_addr[ADDR_W-1 -: TAG_W]);
    assign valid      = valid_r[cmp_idx];
    assign dirty      = dirty_r[cmp_idx];
    assign victim_tag = tag_q;

    // A set being filled must never report a hit at the same time
    a_no_hit_during_fill: assert property (
        @(posedge clk) disable iff (reset)
        fill_wr |-> !(hit && (fill_idx == cmp_idx))
    );

endmodule

// ==== logic/dcache_controller.sv ====
// Cache controller: combines way hits, keeps LRU and runs the write-back and fill FSM
`timescale 1ns/10ps

module dcache_controller #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_geom_pkg::ADDR_W - dcache_geom_pkg::OFFSET_W - IDX_W
) (
    input  logic                   clk,
    input  logic                   reset,
    // CPU port
    input  dcache_geom_pkg::addr_t c_addr,
    input  dcache_geom_pkg::word_t c_wdata,
    input  dcache_geom_pkg::be_t   c_bytesel,
    input  logic                   c_wr_en,
    input  logic                   c_access,
    output dcache_geom_pkg::word_t c_rdata,
    output logic                   c_ack,
    // Memory port
    output dcache_geom_pkg::addr_t m_addr,
    output dcache_geom_pkg::word_t m_wdata,
    output dcache_geom_pkg::be_t   m_bytesel,
    output logic                   m_wr_en,
    output logic                   m_access,
    input  dcache_geom_pkg::word_t m_rdata,
    input  logic                   m_ack,
    // Way results
    input  logic                   hit0,
    input  logic                   hit1,
    input  dcache_geom_pkg::word_t rd_data0,
    input  dcache_geom_pkg::word_t rd_data1,
    input  logic                   valid0,
    input  logic                   valid1,
    input  logic                   dirty0,
    input  logic                   dirty1,
    input  logic [TAG_W-1:0]       victim_tag0,
    input  logic [TAG_W-1:0]       victim_tag1,
    input  dcache_geom_pkg::word_t wb_data0,
    input  dcache_geom_pkg::word_t wb_data1,
    // Way controls
    output dcache_geom_pkg::addr_t lookup_addr,
    output dcache_geom_pkg::addr_t compare_addr,
    output logic                   cpu_wr0,
    output logic                   cpu_wr1,
    output dcache_geom_pkg::addr_t cpu_addr,
    output dcache_geom_pkg::word_t cpu_wdata,
    output dcache_geom_pkg::be_t   cpu_bytesel,
    output logic                   fill_start0,
    output logic                   fill_start1,
    output logic                   fill_wr0,
    output logic                   fill_wr1,
    output dcache_geom_pkg::addr_t fill_addr,
    output dcache_geom_pkg::word_t fill_wdata,
    output logic                   fill_done0,
    output logic                   fill_done1,
    output dcache_geom_pkg::addr_t wb_addr,
    output logic                   wb_clean0,
    output logic                   wb_clean1
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    localparam logic [OFFSET_W-1:0] LAST_BEAT = OFFSET_W'(LINE_WORDS - 1);

    ctrl_state_t         state;
    mem_op_t             mem_op;
    logic                accessing;
    logic [OFFSET_W-1:0] beat;
    logic                victim;
    logic [SETS-1:0]     lru;

    // Held request
    addr_t               req_addr;
    word_t               req_wdata;
    be_t                 req_be;
    logic                req_wr;
    logic [TAG_W-1:0]    wb_tag;

    logic [IDX_W-1:0]    req_idx;
    logic [TAG_W-1:0]    req_tag;
    logic                lookup_done;
    logic                miss;
    logic                victim_pick;
    logic                victim_dirty;
    logic                fill_way;
    logic                last_beat;
    logic                wb_last;
    logic                fill_beat;
    logic                fill_last;
    logic                enter_fill;

    assign req_idx = req_addr[OFFSET_W +: IDX_W];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];

    // ------------------------------------------------------------------
    // Hit combining
    // ------------------------------------------------------------------
    assign lookup_done = accessing && (state == IDLE);
    assign c_ack       = lookup_done && (hit0 || hit1);
    assign miss        = lookup_done && !(hit0 || hit1);
    assign c_rdata     = hit0 ? rd_data0 : rd_data1;

    // Invalid ways are filled first, otherwise LRU names the victim
    assign victim_pick  = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru[req_idx]);
    assign victim_dirty = victim_pick ? (valid1 && dirty1) : (valid0 && dirty0);

    assign last_beat  = (beat == LAST_BEAT);
    assign wb_last    = (state == WB_SEND) && m_ack && last_beat;
    assign fill_beat  = (state == FILL) && m_ack;
    assign fill_last  = fill_beat && last_beat;
    assign enter_fill = (miss && !victim_dirty) || wb_last;
    // Victim register is not loaded yet in the miss cycle
    assign fill_way   = miss ? victim_pick : victim;

    // ------------------------------------------------------------------
    // Way control
    // ------------------------------------------------------------------
    assign lookup_addr  = (state == IDLE) ? c_addr : req_addr;
    assign compare_addr = req_addr;

    assign cpu_addr    = req_addr;
    assign cpu_wdata   = req_wdata;
    assign cpu_bytesel = req_be;
    assign cpu_wr0     = (c_ack && req_wr && hit0) || ((state == APPLY_WRITE) && !victim);
    assign cpu_wr1     = (c_ack && req_wr && hit1) || ((state == APPLY_WRITE) && victim);

    assign fill_addr   = {req_tag, req_idx, beat};
    assign fill_wdata  = m_rdata;
    assign fill_start0 = enter_fill && !fill_way;
    assign fill_start1 = enter_fill && fill_way;
    assign fill_wr0    = fill_beat && !victim;
    assign fill_wr1    = fill_beat && victim;
    assign fill_done0  = fill_last && !victim;
    assign fill_done1  = fill_last && victim;

    assign wb_addr   = {wb_tag, req_idx, beat};
    assign wb_clean0 = wb_last && !victim;
    assign wb_clean1 = wb_last && victim;

    // ------------------------------------------------------------------
    // Memory port
    // ------------------------------------------------------------------
    always_comb begin
        unique case (state)
            WB_SEND: mem_op = MEM_WRITE;
            FILL:    mem_op = MEM_READ;
            default: mem_op = MEM_NONE;
        endcase
    end

    assign m_access  = (mem_op != MEM_NONE);
    assign m_wr_en   = (mem_op == MEM_WRITE);
    assign m_addr    = (mem_op == MEM_WRITE) ? wb_addr : fill_addr;
    assign m_wdata   = victim ? wb_data1 : wb_data0;
    assign m_bytesel = '1;

    // Request is captured on every idle edge, so it stays put during a miss
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr  <= c_addr;
            req_wdata <= c_wdata;
            req_be    <= c_bytesel;
            req_wr    <= c_wr_en;
        end
        if (miss) begin
            wb_tag <= victim_pick ? victim_tag1 : victim_tag0;
        end
    end

    // ------------------------------------------------------------------
    // Miss sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            accessing <= 1'b0;
            beat      <= '0;
            victim    <= 1'b0;
            lru       <= '0;
        end else begin
            // Leaving a miss forces one fresh lookup before the ack
            if (state == IDLE) begin
                accessing <= c_access && !c_ack;
            end else begin
                accessing <= 1'b0;
            end

            // LRU bit always names the way not just used
            if (c_ack) begin
                lru[req_idx] <= hit0;
            end else if (fill_last) begin
                lru[req_idx] <= !victim;
            end

            unique case (state)
                IDLE: begin
                    if (miss) begin
                        victim <= victim_pick;
                        beat   <= '0;
                        state  <= victim_dirty ? WB_READ : FILL;
                    end
                end
                WB_READ: begin
                    state <= WB_SEND;
                end
                WB_SEND: begin
                    if (m_ack) begin
                        beat  <= beat + 1'b1;
                        state <= last_beat ? FILL : WB_READ;
                    end
                end
                FILL: begin
                    if (m_ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= req_wr ? APPLY_WRITE : IDLE;
                        end
                    end
                end
                APPLY_WRITE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_ack_with_access: assert property (
        @(posedge clk) disable iff (reset)
        $rose(c_ack) |-> c_access
    );

    // Memory request held until acknowledged
    a_mem_hold: assert property (
        @(posedge clk) disable iff (reset)
        (m_access && !m_ack) |=> (m_access && $stable(m_addr) && $stable(m_wr_en))
    );

    a_single_way_hit: assert property (
        @(posedge clk) disable iff (reset)
        !(hit0 && hit1)
    );

endmodule

// ==== logic/dcache_2way.sv ====
// Top level of the two-way data cache, joining both way stores and the controller
`timescale 1ns/10ps

module dcache_2way #(
    parameter int SETS = 256,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = dcache_geom_pkg::ADDR_W - dcache_geom_pkg::OFFSET_W - IDX_W
) (
    input  logic                   clk,
    input  logic                   reset,
    // CPU data port
    input  dcache_geom_pkg::addr_t c_addr,
    input  dcache_geom_pkg::word_t c_wdata,
    input  dcache_geom_pkg::be_t   c_bytesel,
    input  logic                   c_wr_en,
    input  logic                   c_access,
    output dcache_geom_pkg::word_t c_rdata,
    output logic                   c_ack,
    // Memory port
    output dcache_geom_pkg::addr_t m_addr,
    output dcache_geom_pkg::word_t m_wdata,
    output dcache_geom_pkg::be_t   m_bytesel,
    output logic                   m_wr_en,
    output logic                   m_access,
    input  dcache_geom_pkg::word_t m_rdata,
    input  logic                   m_ack
);
    import dcache_geom_pkg::*;

    // Per-way results
    logic             hit0, hit1;
    word_t            rd_data0, rd_data1;
    logic             valid0, valid1;
    logic             dirty0, dirty1;
    logic [TAG_W-1:0] victim_tag0, victim_tag1;
    word_t            wb_data0, wb_data1;

    // Shared way controls
    addr_t            lookup_addr, compare_addr;
    addr_t            cpu_addr, fill_addr, wb_addr;
    word_t            cpu_wdata, fill_wdata;
    be_t              cpu_bytesel;
    logic             cpu_wr0, cpu_wr1;
    logic             fill_start0, fill_start1;
    logic             fill_wr0, fill_wr1;
    logic             fill_done0, fill_done1;
    logic             wb_clean0, wb_clean1;

    dcache_way #(.SETS(SETS)) way0 (
        .clk, .reset, .lookup_addr, .compare_addr,
        .hit(hit0), .rd_data(rd_data0), .valid(valid0), .dirty(dirty0),
        .victim_tag(victim_tag0),
        .cpu_wr(cpu_wr0), .cpu_addr, .cpu_wdata, .cpu_bytesel,
        .fill_start(fill_start0), .fill_wr(fill_wr0), .fill_addr, .fill_wdata,
        .fill_done(fill_done0),
        .wb_addr, .wb_data(wb_data0), .wb_clean(wb_clean0)
    );

    dcache_way #(.SETS(SETS)) way1 (
        .clk, .reset, .lookup_addr, .compare_addr,
        .hit(hit1), .rd_data(rd_data1), .valid(valid1), .dirty(dirty1),
        .victim_tag(victim_tag1),
        .cpu_wr(cpu_wr1), .cpu_addr, .cpu_wdata, .cpu_bytesel,
        .fill_start(fill_start1), .fill_wr(fill_wr1), .fill_addr, .fill_wdata,
        .fill_done(fill_done1),
        .wb_addr, .wb_data(wb_data1), .wb_clean(wb_clean1)
    );

    // Controller port names match the wires and ports above
    dcache_controller #(.SETS(SETS)) ctrl0 (.*);

endmodule

// ==== verification/mem_model.sv ====
// Testbench memory for the data cache: answers the memory port with random wait states
`timescale 1ns/10ps

module mem_model (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_geom_pkg::addr_t m_addr,
    input  dcache_geom_pkg::word_t m_wdata,
    input  dcache_geom_pkg::be_t   m_bytesel,
    input  logic                   m_wr_en,
    input  logic                   m_access,
    output dcache_geom_pkg::word_t m_rdata,
    output logic                   m_ack
);
    import dcache_geom_pkg::*;

    localparam int DEPTH = 2**ADDR_W;

    word_t mem [DEPTH];
    addr_t read_log [$];
    int    read_count;
    int    write_count;
    int    partial_writes;
    int    wait_left;
    logic  busy;

    // Start contents mix every address bit into the word
    function automatic word_t pattern_word(input int unsigned a);
        logic [31:0] h;
        h = a * 32'h9e37_79b9;
        return h[31:16] ^ h[15:0];
    endfunction

    task automatic serve_request();
        busy  = 1'b0;
        m_ack = 1'b1;
        if (m_wr_en) begin
            write_count++;
            if (m_bytesel != '1) begin
                partial_writes++;
            end
            for (int b = 0; b < BE_W; b++) begin
                if (m_bytesel[b]) begin
                    mem[m_addr][8*b +: 8] = m_wdata[8*b +: 8];
                end
            end
        end else begin
            read_count++;
            read_log.push_back(m_addr);
            m_rdata = mem[m_addr];
        end
    endtask

    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = pattern_word(a);
        end
        read_count     = 0;
        write_count    = 0;
        partial_writes = 0;
        wait_left      = 0;
        busy           = 1'b0;
        m_rdata        = '0;
        m_ack          = 1'b0;
    end

    // One request per ack, and the ack drops for a cycle before the next one
    always @(posedge clk) begin
        #1;
        if (reset) begin
            m_ack = 1'b0;
            busy  = 1'b0;
        end else if (m_ack) begin
            m_ack = 1'b0;
        end else if (m_access) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                serve_request();
            end else begin
                wait_left--;
            end
        end
    end

endmodule

// ==== verification/tb_dcache_2way.sv ====
// Top-level testbench that runs directed tests on the two-way data cache against a shadow memory
`timescale 1ns/10ps

module tb_dcache_2way;
    import dcache_geom_pkg::*;

    localparam int SETS         = 256;
    localparam int IDX_W        = $clog2(SETS);
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_OPS   = 200;
    // Accesses of the directed tests plus the random mix
    localparam int ACCESS_TOTAL = 2 + 3 + 2 + 6 + 4 + RANDOM_OPS;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + ACCESS_TOTAL * 60) * CLK_PERIOD;

    logic  clk;
    logic  reset;
    addr_t c_addr;
    word_t c_wdata;
    be_t   c_bytesel;
    logic  c_wr_en;
    logic  c_access;
    word_t c_rdata;
    logic  c_ack;
    addr_t m_addr;
    word_t m_wdata;
    be_t   m_bytesel;
    logic  m_wr_en;
    logic  m_access;
    word_t m_rdata;
    logic  m_ack;

    word_t shadow [2**ADDR_W];
    int    error_count;
    int    check_count;

    dcache_2way #(.SETS(SETS)) dut0 (.*);
    mem_model mem0 (.*);

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic addr_t line_addr(input int tag, input int set, input int offset);
        return addr_t'((tag << (OFFSET_W + IDX_W)) | (set << OFFSET_W) | offset);
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input be_t be);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
        end
    endtask

    // Level request held until the ack is seen, then dropped in the next cycle
    task automatic cpu_access(input addr_t addr, input logic wr, input word_t wdata,
                              input be_t be, output word_t rdata);
        @(posedge clk);
        #1;
        c_addr    = addr;
        c_wr_en   = wr;
        c_wdata   = wdata;
        c_bytesel = be;
        c_access  = 1'b1;
        do begin
            @(negedge clk);
        end while (!c_ack);
        rdata = c_rdata;
        @(posedge clk);
        #1;
        c_access = 1'b0;
    endtask

    task automatic read_and_check(input string test_name, input addr_t addr);
        word_t data;
        cpu_access(addr, 1'b0, '0, '1, data);
        check_value(test_name, shadow[addr], data);
    endtask

    task automatic write_word(input addr_t addr, input word_t wdata, input be_t be);
        word_t ignored;
        cpu_access(addr, 1'b1, wdata, be, ignored);
        shadow[addr] = merge_bytes(shadow[addr], wdata, be);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic read_miss_then_hit();
        int reads;
        int log_start;
        reads     = mem0.read_count;
        log_start = mem0.read_log.size();
        read_and_check("read_miss", line_addr(1, 'h12, 5));
        check_value("read_miss_count", reads + 8, mem0.read_count);
        for (int i = 0; i < LINE_WORDS; i++) begin
            check_value("read_miss_order", line_addr(1, 'h12, i), mem0.read_log[log_start + i]);
        end
        read_and_check("read_hit", line_addr(1, 'h12, 5));
        check_value("read_hit_count", reads + 8, mem0.read_count);
    endtask

    task automatic write_hit_byte_merge();
        int reads;
        int writes;
        reads  = mem0.read_count;
        writes = mem0.write_count;
        write_word(line_addr(1, 'h12, 5), 16'ha1b2, 2'b01);
        write_word(line_addr(1, 'h12, 5), 16'hc3d4, 2'b10);
        read_and_check("write_hit_merge", line_addr(1, 'h12, 5));
        check_value("write_hit_reads", reads, mem0.read_count);
        check_value("write_hit_writes", writes, mem0.write_count);
    endtask

    task automatic write_miss_allocate();
        int reads;
        int writes;
        reads  = mem0.read_count;
        writes = mem0.write_count;
        write_word(line_addr(2, 'h20, 3), 16'h5e6f, 2'b10);
        check_value("write_miss_reads", reads + 8, mem0.read_count);
        check_value("write_miss_writes", writes, mem0.write_count);
        read_and_check("write_miss_merge", line_addr(2, 'h20, 3));
    endtask

    // A, B and C share set 0x30
    task automatic lru_replacement();
        int reads;
        read_and_check("lru_fill_a", line_addr(3, 'h30, 0));
        read_and_check("lru_fill_b", line_addr(4, 'h30, 2));
        read_and_check("lru_touch_a", line_addr(3, 'h30, 0));
        read_and_check("lru_fill_c", line_addr(5, 'h30, 4));
        reads = mem0.read_count;
        read_and_check("lru_keep_a", line_addr(3, 'h30, 1));
        check_value("lru_keep_a_reads", reads, mem0.read_count);
        read_and_check("lru_evict_b", line_addr(4, 'h30, 2));
        check_value("lru_evict_b_reads", reads + 8, mem0.read_count);
    endtask

    task automatic dirty_writeback();
        int writes;
        int partial;
        write_word(line_addr(6, 'h40, 1), 16'h1357, 2'b11);
        write_word(line_addr(6, 'h40, 6), 16'h2468, 2'b01);
        read_and_check("wb_fill_e", line_addr(7, 'h40, 0));
        writes  = mem0.write_count;
        partial = mem0.partial_writes;
        read_and_check("wb_fill_f", line_addr(8, 'h40, 5));
        check_value("wb_write_count", writes + 8, mem0.write_count);
        check_value("wb_bytesel", partial, mem0.partial_writes);
        for (int i = 0; i < LINE_WORDS; i++) begin
            check_value("wb_mem_contents", shadow[line_addr(6, 'h40, i)],
                        mem0.mem[line_addr(6, 'h40, i)]);
        end
    endtask

    // Six tags over four sets keep both ways busy with evictions
    task automatic random_mix();
        addr_t a;
        word_t wdata;
        be_t   be;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            a = line_addr($urandom_range(5, 0), 'h50 + $urandom_range(3, 0),
                          $urandom_range(7, 0));
            if ($urandom_range(1, 0) == 1) begin
                wdata = word_t'($urandom());
                be    = be_t'($urandom_range(3, 1));
                write_word(a, wdata, be);
            end else begin
                read_and_check("random_read", a);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Sequence, watchdog and summary
    // ------------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the cache did not finish the tests within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'h573c));
        error_count = 0;
        check_count = 0;
        reset       = 1'b1;
        c_addr      = '0;
        c_wdata     = '0;
        c_bytesel   = '0;
        c_wr_en     = 1'b0;
        c_access    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            shadow[a] = mem0.mem[a];
        end

        read_miss_then_hit();
        write_hit_byte_merge();
        write_miss_allocate();
        lru_replacement();
        dirty_writeback();
        random_mix();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/dcache_geom_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_way.sv
logic/dcache_controller.sv
logic/dcache_2way.sv
verification/mem_model.sv
verification/tb_dcache_2way.sv

// ==== Bender.yml ====
package:
  name: dcache_2way

sources:
  # Packages first, then the design from the leaves up
  - logic/dcache_geom_pkg.sv
  - logic/dcache_ctrl_pkg.sv
  - logic/dcache_way.sv
  - logic/dcache_controller.sv
  - logic/dcache_2way.sv

  - target: test
    files:
      - verification/mem_model.sv
      - verification/tb_dcache_2way.sv
